/* design/bus_cfg.svh */
`ifndef BUS_CFG_SVH
`define BUS_CFG_SVH

// bus widths
`define BUS_ADDR_W    32
`define BUS_DATA_W    32
`define BUS_AXI_W     64

// machine timer words, read only
`define BUS_CLINT_LO  32'h0200_BFF8
`define BUS_CLINT_HI  32'h0200_BFFC

// backing memory window
`define BUS_MEM_BASE  32'h8000_0000
`define BUS_MEM_WORDS 256

`endif

/* design/bus_pkg.sv */
`include "bus_cfg.svh"

package bus_pkg;

  typedef logic [`BUS_ADDR_W-1:0]   addr_t;
  typedef logic [`BUS_DATA_W-1:0]   word_t;
  typedef logic [`BUS_AXI_W-1:0]    axi_data_t;
  typedef logic [`BUS_DATA_W/8-1:0] cstrb_t;
  typedef logic [`BUS_AXI_W/8-1:0]  axi_strb_t;
  typedef logic [2:0]               axi_size_t;
  typedef logic [1:0]               axi_resp_t;

  localparam axi_size_t size_byte = 3'b000;
  localparam axi_size_t size_half = 3'b001;
  localparam axi_size_t size_word = 3'b010;
  localparam axi_resp_t resp_okay = 2'b00;

  // single-beat AXI4 payloads, valid/ready travel separately
  typedef struct packed {addr_t addr; axi_size_t size;} axi_ar_t;
  typedef struct packed {axi_data_t data; axi_resp_t resp;} axi_r_t;
  typedef struct packed {addr_t addr; axi_size_t size;} axi_aw_t;
  typedef struct packed {axi_data_t data; axi_strb_t strb;} axi_w_t;
  typedef struct packed {axi_resp_t resp;} axi_b_t;

  // client side requests
  typedef struct packed {addr_t addr;} fetch_req_t;
  typedef struct packed {addr_t addr; cstrb_t strb;} load_req_t;

  typedef struct packed {
    addr_t  addr;
    word_t  data;
    cstrb_t strb;   // unshifted, lane 0 based
  } store_req_t;

  typedef enum logic [2:0] {
    fetch_addr,
    fetch_data,
    ls_addr,
    ls_read,
    ls_write
  } arb_state_t;

endpackage

/* design/clint_timer.sv */
`include "bus_cfg.svh"

module clint_timer
  import bus_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  rd_valid_i,
  input  addr_t rd_addr_i,
  output logic  rd_valid_o,
  output word_t rd_data_o
);

  logic [63:0] mtime;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime      <= '0;
      rd_valid_o <= 1'b0;
    end
    else
    begin
      mtime      <= mtime + 64'd1;
      rd_valid_o <= rd_valid_i;   // fixed one cycle latency
    end
  end

  // bit 2 picks the high word
  always_ff @(posedge clk)
  begin
    if (rd_valid_i)
      rd_data_o <= rd_addr_i[2] ? mtime[63:32] : mtime[31:0];
  end

  a_timer_addr: assert property (@(posedge clk) disable iff (rst)
    rd_valid_i |-> (rd_addr_i == `BUS_CLINT_LO || rd_addr_i == `BUS_CLINT_HI));

endmodule

/* design/axi_sram.sv */
`include "bus_cfg.svh"

module axi_sram
  import bus_pkg::*;
(
  input  logic    clk,
  input  logic    rst,

  input  logic    ar_valid_i,
  input  axi_ar_t ar_i,
  output logic    ar_ready_o,
  output logic    r_valid_o,
  output axi_r_t  r_o,

  input  logic    aw_valid_i,
  input  axi_aw_t aw_i,
  input  logic    w_valid_i,
  input  axi_w_t  w_i,
  output logic    aw_ready_o,
  output logic    w_ready_o,
  output logic    b_valid_o,
  output axi_b_t  b_o
);

  localparam int idx_w = $clog2(`BUS_MEM_WORDS);

  axi_data_t mem [`BUS_MEM_WORDS];

  logic             idle;
  logic             rd_fire;
  logic             wr_fire;
  addr_t            rd_off;
  addr_t            wr_off;
  logic [idx_w-1:0] rd_idx;
  logic [idx_w-1:0] wr_idx;

  // one transaction in flight at a time
  assign idle       = !r_valid_o && !b_valid_o;
  assign ar_ready_o = idle;
  assign aw_ready_o = idle;
  assign w_ready_o  = idle;

  assign rd_fire = ar_valid_i && ar_ready_o;
  assign wr_fire = aw_valid_i && w_valid_i && idle;

  assign rd_off = ar_i.addr - `BUS_MEM_BASE;
  assign wr_off = aw_i.addr - `BUS_MEM_BASE;
  assign rd_idx = rd_off[idx_w+2:3];   // 8 byte words
  assign wr_idx = wr_off[idx_w+2:3];

  assign b_o = '{resp: resp_okay};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      r_valid_o <= 1'b0;
      b_valid_o <= 1'b0;
    end
    else
    begin
      r_valid_o <= rd_fire;
      b_valid_o <= wr_fire;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_fire)
    begin
      for (int b = 0; b < `BUS_AXI_W/8; b++)
      begin
        if (w_i.strb[b])
          mem[wr_idx][b*8 +: 8] <= w_i.data[b*8 +: 8];
      end
    end
    if (rd_fire)
      r_o <= '{data: mem[rd_idx], resp: resp_okay};
  end

  a_aw_w_together: assert property (@(posedge clk) disable iff (rst)
    ($rose(aw_valid_i) || $rose(w_valid_i)) |-> (aw_valid_i && w_valid_i));

endmodule

/* design/bus_arbiter.sv */
`include "bus_cfg.svh"

module bus_arbiter
  import bus_pkg::*;
(
  input  logic       clk,
  input  logic       rst,

  input  logic       fetch_valid_i,
  input  fetch_req_t fetch_req_i,
  output logic       fetch_rvalid_o,
  output word_t      fetch_rdata_o,

  input  logic       load_valid_i,
  input  load_req_t  load_req_i,
  output logic       load_rvalid_o,
  output word_t      load_rdata_o,

  input  logic       store_valid_i,
  input  store_req_t store_req_i,
  output logic       store_done_o,

  output logic       ar_valid_o,
  output axi_ar_t    ar_o,
  input  logic       ar_ready_i,
  input  logic       r_valid_i,
  input  axi_r_t     r_i,
  output logic       aw_valid_o,
  output axi_aw_t    aw_o,
  output logic       w_valid_o,
  output axi_w_t     w_o,
  input  logic       aw_ready_i,
  input  logic       w_ready_i,
  input  logic       b_valid_i,
  input  axi_b_t     b_i
);

  arb_state_t state;
  arb_state_t next_state;

  logic   ls_pending;
  logic   clint_hit;
  logic   timer_rd_valid;
  logic   timer_rvalid;
  word_t  timer_rdata;
  word_t  st_data;
  cstrb_t st_strb;

  function automatic axi_size_t size_of(input cstrb_t strb);
    case (strb)
      4'h1:    return size_byte;
      4'h3:    return size_half;
      default: return size_word;
    endcase
  endfunction

  assign ls_pending = load_valid_i || store_valid_i;
  assign clint_hit  = (load_req_i.addr == `BUS_CLINT_LO) || (load_req_i.addr == `BUS_CLINT_HI);

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= fetch_addr;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    case (state)
      fetch_addr:
      begin
        if (ls_pending)
          next_state = ls_addr;   // load/store wins over fetch
        else if (fetch_valid_i && ar_ready_i)
          next_state = fetch_data;
      end
      fetch_data:
      begin
        if (r_valid_i)
          next_state = ls_pending ? ls_addr : fetch_addr;
      end
      ls_addr:
      begin
        if (load_valid_i && (clint_hit || ar_ready_i))
          next_state = ls_read;
        else if (store_valid_i && aw_ready_i && w_ready_i)
          next_state = ls_write;
        else if (!ls_pending)
          next_state = fetch_addr;
      end
      ls_read:
      begin
        if (r_valid_i || timer_rvalid)
          next_state = fetch_addr;
      end
      ls_write:
      begin
        if (b_valid_i)
          next_state = fetch_addr;
      end
      default: next_state = fetch_addr;
    endcase
  end

  // read address, shared by fetch and memory loads
  assign ar_valid_o = (state == fetch_addr && fetch_valid_i && !ls_pending) ||
                      (state == ls_addr && load_valid_i && !clint_hit);

  always_comb
  begin
    if (state == ls_addr)
      ar_o = '{addr: load_req_i.addr, size: size_of(load_req_i.strb)};
    else
      ar_o = '{addr: fetch_req_i.addr, size: size_word};
  end

  // store lanes, then replicate to both halves
  assign st_data = store_req_i.data << {store_req_i.addr[1:0], 3'b000};
  assign st_strb = store_req_i.strb << store_req_i.addr[1:0];

  assign aw_valid_o = (state == ls_addr) && store_valid_i;
  assign w_valid_o  = aw_valid_o;
  assign aw_o = '{addr: store_req_i.addr, size: size_of(store_req_i.strb)};

  always_comb
  begin
    w_o.data = {st_data, st_data};
    w_o.strb = store_req_i.addr[2] ? {st_strb, 4'h0} : {4'h0, st_strb};
  end

  // responses, halves picked by addr bit 2
  assign fetch_rvalid_o = (state == fetch_data) && r_valid_i;
  assign fetch_rdata_o  = fetch_req_i.addr[2] ? r_i.data[63:32] : r_i.data[31:0];

  assign load_rvalid_o = (state == ls_read) && (r_valid_i || timer_rvalid);
  assign load_rdata_o  = timer_rvalid ? timer_rdata :
                         load_req_i.addr[2] ? r_i.data[63:32] : r_i.data[31:0];

  assign store_done_o = (state == ls_write) && b_valid_i;

  assign timer_rd_valid = (state == ls_addr) && load_valid_i && clint_hit;

  clint_timer u_clint (
    .clk        (clk),
    .rst        (rst),
    .rd_valid_i (timer_rd_valid),
    .rd_addr_i  (load_req_i.addr),
    .rd_valid_o (timer_rvalid),
    .rd_data_o  (timer_rdata)
  );

  a_r_okay: assert property (@(posedge clk) disable iff (rst)
    r_valid_i |-> r_i.resp == resp_okay);
  a_b_okay: assert property (@(posedge clk) disable iff (rst)
    b_valid_i |-> b_i.resp == resp_okay);
  a_ld_st_excl: assert property (@(posedge clk) disable iff (rst)
    !(load_valid_i && store_valid_i));

endmodule

/* design/mem_subsystem_top.sv */
module mem_subsystem_top
  import bus_pkg::*;
(
  input  logic       clk,
  input  logic       rst,

  input  logic       fetch_valid_i,
  input  fetch_req_t fetch_req_i,
  output logic       fetch_rvalid_o,
  output word_t      fetch_rdata_o,

  input  logic       load_valid_i,
  input  load_req_t  load_req_i,
  output logic       load_rvalid_o,
  output word_t      load_rdata_o,

  input  logic       store_valid_i,
  input  store_req_t store_req_i,
  output logic       store_done_o
);

  logic    ar_valid;
  axi_ar_t ar;
  logic    ar_ready;
  logic    r_valid;
  axi_r_t  r;
  logic    aw_valid;
  axi_aw_t aw;
  logic    w_valid;
  axi_w_t  w;
  logic    aw_ready;
  logic    w_ready;
  logic    b_valid;
  axi_b_t  b;

  bus_arbiter u_arb (
    .clk            (clk),
    .rst            (rst),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_req_i    (fetch_req_i),
    .fetch_rvalid_o (fetch_rvalid_o),
    .fetch_rdata_o  (fetch_rdata_o),
    .load_valid_i   (load_valid_i),
    .load_req_i     (load_req_i),
    .load_rvalid_o  (load_rvalid_o),
    .load_rdata_o   (load_rdata_o),
    .store_valid_i  (store_valid_i),
    .store_req_i    (store_req_i),
    .store_done_o   (store_done_o),
    .ar_valid_o     (ar_valid),
    .ar_o           (ar),
    .ar_ready_i     (ar_ready),
    .r_valid_i      (r_valid),
    .r_i            (r),
    .aw_valid_o     (aw_valid),
    .aw_o           (aw),
    .w_valid_o      (w_valid),
    .w_o            (w),
    .aw_ready_i     (aw_ready),
    .w_ready_i      (w_ready),
    .b_valid_i      (b_valid),
    .b_i            (b)
  );

  // stand-in for the rest of the system
  axi_sram u_sram (
    .clk        (clk),
    .rst        (rst),
    .ar_valid_i (ar_valid),
    .ar_i       (ar),
    .ar_ready_o (ar_ready),
    .r_valid_o  (r_valid),
    .r_o        (r),
    .aw_valid_i (aw_valid),
    .aw_i       (aw),
    .w_valid_i  (w_valid),
    .w_i        (w),
    .aw_ready_o (aw_ready),
    .w_ready_o  (w_ready),
    .b_valid_o  (b_valid),
    .b_o        (b)
  );

endmodule

/* verification/tb_tests.svh */
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

localparam int n_fill      = 32;   // 32-bit words in the test window
localparam int n_word      = 32;
localparam int n_partial   = 24;
localparam int n_fetch     = 8;
localparam int n_pair      = 4;
localparam int n_mix_fetch = 80;
localparam int n_mix_ls    = 120;
localparam int n_txn = n_fill + 2 * n_word + 2 * n_partial + n_fetch + 2 * n_pair + 3 +
                       n_mix_fetch + n_mix_ls;

logic [7:0] shadow [0:4*n_fill-1];

function automatic addr_t rand_word_addr();
  logic [31:0] r;
  r = $random(seed);
  return `BUS_MEM_BASE + {25'd0, r[4:0], 2'b00};
endfunction

function automatic word_t model_word(input addr_t addr);
  int off;
  off = int'(addr - `BUS_MEM_BASE) & ~3;
  return {shadow[off+3], shadow[off+2], shadow[off+1], shadow[off]};
endfunction

// strobe bit i moves to byte i plus the address offset
task automatic model_store(input addr_t addr, input word_t data, input cstrb_t strb);
  int base;
  int lane;
  base = int'(addr - `BUS_MEM_BASE) & ~3;
  lane = int'(addr[1:0]);
  for (int i = 0; i < 4; i++)
  begin
    if (strb[i] && i + lane < 4)
      shadow[base+i+lane] = data[i*8 +: 8];
  end
endtask

task automatic idle_cycles(input int n);
  if (n > 0)
  begin
    repeat (n) @(posedge clk);
    #1;
  end
endtask

task automatic random_store(input logic allow_word, output addr_t word_addr);
  logic [31:0] r;
  addr_t       addr;
  word_t       data;
  cstrb_t      strb;
  r         = $random(seed);
  data      = $random(seed);
  word_addr = rand_word_addr();
  if (allow_word && r[3:2] == 2'b11)
  begin
    strb = 4'hF;
    addr = word_addr;
  end
  else if (r[0])
  begin
    strb = 4'h3;
    addr = word_addr | {30'd0, r[1], 1'b0};   // half on a 2 byte boundary
  end
  else
  begin
    strb = 4'h1;
    addr = word_addr | {30'd0, r[2:1]};
  end
  store_bytes(addr, data, strb);
  model_store(addr, data, strb);
endtask

task automatic report_test(input string name, input int checks0, input int fails0);
  $display("%s finished: %0d checks, %0d failed", name,
           pass_count + fail_count - checks0, fail_count - fails0);
endtask

task automatic word_store_load();
  int    checks0;
  int    fails0;
  addr_t addr;
  word_t data;
  word_t got;
  checks0 = pass_count + fail_count;
  fails0  = fail_count;
  for (int i = 0; i < n_fill; i++)
  begin
    addr = `BUS_MEM_BASE + 32'(i * 4);   // fills both halves of each 64-bit word
    data = $random(seed);
    store_bytes(addr, data, 4'hF);
    model_store(addr, data, 4'hF);
  end
  for (int i = 0; i < n_word; i++)
  begin
    addr = rand_word_addr();
    data = $random(seed);
    store_bytes(addr, data, 4'hF);
    model_store(addr, data, 4'hF);
    load_word(addr, got);
    check_value("word_store_load", model_word(addr), got);
  end
  report_test("word_store_load", checks0, fails0);
endtask

task automatic partial_stores();
  int    checks0;
  int    fails0;
  addr_t addr;
  word_t got;
  checks0 = pass_count + fail_count;
  fails0  = fail_count;
  for (int i = 0; i < n_partial; i++)
  begin
    random_store(1'b0, addr);
    load_word(addr, got);
    check_value("partial_stores", model_word(addr), got);
  end
  report_test("partial_stores", checks0, fails0);
endtask

task automatic fetch_and_load();
  int    checks0;
  int    fails0;
  addr_t fa;
  addr_t la;
  word_t fd;
  word_t ld;
  checks0 = pass_count + fail_count;
  fails0  = fail_count;
  for (int i = 0; i < n_fetch; i++)
  begin
    fa = rand_word_addr();
    fetch_word(fa, fd);
    check_value("fetch_and_load", model_word(fa), fd);
  end
  for (int i = 0; i < n_pair; i++)
  begin
    fa = rand_word_addr();
    la = rand_word_addr();
    fork
      fetch_word(fa, fd);
      load_word(la, ld);
    join
    check_value("fetch_and_load", model_word(fa), fd);
    check_value("fetch_and_load", model_word(la), ld);
    check_value("fetch_and_load", 32'd1, word_t'(load_seen_at < fetch_seen_at));
  end
  report_test("fetch_and_load", checks0, fails0);
endtask

task automatic timer_reads();
  int    checks0;
  int    fails0;
  word_t t0;
  word_t t1;
  word_t hi;
  checks0 = pass_count + fail_count;
  fails0  = fail_count;
  load_word(`BUS_CLINT_LO, t0);
  idle_cycles(10);
  load_word(`BUS_CLINT_LO, t1);
  check_value("timer_reads", 32'd1, word_t'(t1 > t0));
  load_word(`BUS_CLINT_HI, hi);
  check_value("timer_reads", 32'd0, hi);   // far from a low word wrap
  report_test("timer_reads", checks0, fails0);
endtask

task automatic mixed_traffic();
  int checks0;
  int fails0;
  checks0 = pass_count + fail_count;
  fails0  = fail_count;
  fork
    begin
      addr_t       fa;
      word_t       fd;
      logic [31:0] r;
      for (int i = 0; i < n_mix_fetch; i++)
      begin
        r  = $random(seed);
        fa = rand_word_addr();
        fetch_word(fa, fd);
        check_value("mixed_traffic", model_word(fa), fd);
        idle_cycles(int'(r[1:0]));
      end
    end
    begin
      addr_t       la;
      word_t       ld;
      logic [31:0] r;
      for (int i = 0; i < n_mix_ls; i++)
      begin
        r = $random(seed);
        if (r[2:0] < 3'd3)
        begin
          la = rand_word_addr();
          load_word(la, ld);
          check_value("mixed_traffic", model_word(la), ld);
        end
        else
          random_store(1'b1, la);
        idle_cycles(int'(r[4:3]));
      end
    end
  join
  report_test("mixed_traffic", checks0, fails0);
endtask

task automatic run_tests();
  word_store_load();
  partial_stores();
  fetch_and_load();
  timer_reads();
  mixed_traffic();
endtask

`endif

/* verification/tb_top.sv */
`include "bus_cfg.svh"

module tb_top
  import bus_pkg::*;
();

  localparam int clk_period = 40;

  logic       clk;
  logic       rst;
  logic       fetch_valid;
  fetch_req_t fetch_req;
  logic       fetch_rvalid;
  word_t      fetch_rdata;
  logic       load_valid;
  load_req_t  load_req;
  logic       load_rvalid;
  word_t      load_rdata;
  logic       store_valid;
  store_req_t store_req;
  logic       store_done;

  int  seed = 20588;
  int  pass_count = 0;
  int  fail_count = 0;
  time fetch_seen_at;
  time load_seen_at;

  mem_subsystem_top uut (
    .clk            (clk),
    .rst            (rst),
    .fetch_valid_i  (fetch_valid),
    .fetch_req_i    (fetch_req),
    .fetch_rvalid_o (fetch_rvalid),
    .fetch_rdata_o  (fetch_rdata),
    .load_valid_i   (load_valid),
    .load_req_i     (load_req),
    .load_rvalid_o  (load_rvalid),
    .load_rdata_o   (load_rdata),
    .store_valid_i  (store_valid),
    .store_req_i    (store_req),
    .store_done_o   (store_done)
  );

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    if (actual !== expected)
    begin
      fail_count++;
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
    end
    else
      pass_count++;
  endtask

  // each client call starts and ends 1 unit after a rising edge
  task automatic fetch_word(input addr_t addr, output word_t data);
    fetch_req.addr = addr;
    fetch_valid    = 1'b1;
    @(negedge clk);
    while (!fetch_rvalid)
      @(negedge clk);
    data          = fetch_rdata;
    fetch_seen_at = $time;
    @(posedge clk);
    #1;
    fetch_valid = 1'b0;
  endtask

  task automatic load_word(input addr_t addr, output word_t data);
    load_req.addr = addr;
    load_req.strb = 4'hF;
    load_valid    = 1'b1;
    @(negedge clk);
    while (!load_rvalid)
      @(negedge clk);
    data         = load_rdata;
    load_seen_at = $time;
    @(posedge clk);
    #1;
    load_valid = 1'b0;
  endtask

  task automatic store_bytes(input addr_t addr, input word_t data, input cstrb_t strb);
    store_req.addr = addr;
    store_req.data = data;
    store_req.strb = strb;
    store_valid    = 1'b1;
    @(negedge clk);
    while (!store_done)
      @(negedge clk);
    @(posedge clk);
    #1;
    store_valid = 1'b0;
  endtask

  `include "tb_tests.svh"

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial
  begin
    rst         = 1'b1;
    fetch_valid = 1'b0;
    fetch_req   = '0;
    load_valid  = 1'b0;
    load_req    = '0;
    store_valid = 1'b0;
    store_req   = '0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    run_tests();
    $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
    if (fail_count == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

  // generous budget per transaction
  initial
  begin
    repeat (n_txn * 60) @(posedge clk);
    $display("timeout: requests still waiting after %0d cycles", n_txn * 60);
    $display("Regression failed");
    $finish;
  end

endmodule

/* project.f */
+incdir+design
+incdir+verification
design/bus_pkg.sv
design/clint_timer.sv
design/axi_sram.sv
design/bus_arbiter.sv
design/mem_subsystem_top.sv
verification/tb_top.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f project.f \
  --top-module tb_top \
  -Mdir obj_dir \
  -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Regression passed$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
